/* list.f */
rtl/fetch_pkg.sv
rtl/cache_pkg.sv
rtl/pc_gen.sv
rtl/icache_array.sv
rtl/icache_ctrl.sv
rtl/perf_counter.sv
rtl/fetch_credit.sv
rtl/fetch_top.sv
tb/tb_mem_model.sv
tb/tb_fetch.sv

/* rtl/cache_pkg.sv */
package cache_pkg;

	// line geometry of the instruction cache
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_BITS      = 32;
	localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;

	// byte offset inside one line, and the word select part of it
	localparam int OFFSET_BITS   = 4;
	localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
	localparam int BYTE_SEL_BITS = OFFSET_BITS - WORD_SEL_BITS;

	// controller states
	// IDLE is left once after reset
	// REFILL_REQ raises the memory request, REFILL_WAIT holds it
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL_REQ,
		REFILL_WAIT
	} cache_state_e;

endpackage

/* rtl/fetch_credit.sv */
`timescale 1ns/1ps

module fetch_credit import fetch_pkg::*; #(
	parameter int CREDITS = 4
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic            issue_i,
	input  logic            credit_return_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] pc4_i,
	input  logic [XLEN-1:0] inst_i,
	input  logic            pred_taken_i,
	output logic            has_credit_o,
	output logic            inst_valid_o,
	output logic [XLEN-1:0] pc_d_o,
	output logic [XLEN-1:0] inst_d_o,
	output logic [XLEN-1:0] pc4_d_o,
	output logic            pred_taken_d_o
);

	localparam int CW = $clog2(CREDITS + 1);

	logic [CW-1:0] credit_q;

	assign has_credit_o = (credit_q != '0);

	// free slots in the decode buffer
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			credit_q <= CW'(CREDITS);
		end else begin
			case ({issue_i, credit_return_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	// fetch/decode boundary
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			inst_valid_o <= 1'b0;
		end else begin
			inst_valid_o <= issue_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue_i) begin
			pc_d_o         <= pc_i;
			inst_d_o       <= inst_i;
			pc4_d_o        <= pc4_i;
			pred_taken_d_o <= pred_taken_i;
		end
	end

	a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
		credit_q <= CREDITS);

	// the controller must never issue into a full decode buffer
	a_issue_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		issue_i |-> has_credit_o);

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

	// width of the pc and of one instruction word
	localparam int XLEN = 32;

	// byte step between two sequential instructions
	localparam int INST_BYTES = 4;

	// next pc source
	// SEL_MISPRED and SEL_ALU also come in on the redirect port
	typedef enum logic [1:0] {
		SEL_SEQ,
		SEL_PRED,
		SEL_MISPRED,
		SEL_ALU
	} pc_sel_e;

endpackage

/* rtl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*, cache_pkg::*; #(
	parameter int              NUM_LINES = 16,
	parameter int              CREDITS   = 4,
	parameter int              CNT_W     = 32,
	parameter logic [XLEN-1:0] RESET_PC  = '0
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	// branch predictor
	input  logic                 pred_taken_i,
	input  logic [XLEN-1:0]      pred_pc_i,
	// redirect from execute
	input  logic                 redirect_i,
	input  pc_sel_e              redirect_sel_i,
	input  logic [XLEN-1:0]      mispred_pc_i,
	input  logic [XLEN-1:0]      alu_pc_i,
	// decode
	input  logic                 credit_return_i,
	output logic                 inst_valid_o,
	output logic [XLEN-1:0]      pc_d_o,
	output logic [XLEN-1:0]      inst_d_o,
	output logic [XLEN-1:0]      pc4_d_o,
	output logic                 pred_taken_d_o,
	// refill memory
	output logic                 mem_req_valid_o,
	output logic [XLEN-1:0]      mem_req_addr_o,
	input  logic                 mem_ready_i,
	input  logic [LINE_BITS-1:0] mem_line_i,
	// status
	output logic                 stall_o,
	output logic [CNT_W-1:0]     no_acc_o,
	output logic [CNT_W-1:0]     no_hit_o,
	output logic [CNT_W-1:0]     no_miss_o
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc4;
	logic [XLEN-1:0] word;
	logic            lookup_hit;
	logic            fill_en;
	logic            issue;
	logic            miss_start;
	logic            has_credit;
	logic            accept_redirect;

	pc_gen #(
		.RESET_PC(RESET_PC)
	) u_pc_gen (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.advance_i        (issue),
		.pred_taken_i     (pred_taken_i),
		.pred_pc_i        (pred_pc_i),
		.redirect_i       (redirect_i),
		.redirect_sel_i   (redirect_sel_i),
		.mispred_pc_i     (mispred_pc_i),
		.alu_pc_i         (alu_pc_i),
		.accept_redirect_i(accept_redirect),
		.pc_o             (pc),
		.pc4_o            (pc4)
	);

	icache_array #(
		.NUM_LINES(NUM_LINES)
	) u_icache_array (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.addr_i     (pc),
		.fill_en_i  (fill_en),
		.fill_line_i(mem_line_i),
		.hit_o      (lookup_hit),
		.word_o     (word)
	);

	icache_ctrl #(
		.NUM_LINES(NUM_LINES)
	) u_icache_ctrl (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.pc_i             (pc),
		.hit_i            (lookup_hit),
		.has_credit_i     (has_credit),
		.redirect_i       (redirect_i),
		.mem_ready_i      (mem_ready_i),
		.issue_o          (issue),
		.miss_start_o     (miss_start),
		.fill_en_o        (fill_en),
		.mem_req_valid_o  (mem_req_valid_o),
		.mem_req_addr_o   (mem_req_addr_o),
		.accept_redirect_o(accept_redirect),
		.stall_o          (stall_o)
	);

	perf_counter #(
		.CNT_W(CNT_W)
	) u_perf_counter (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.hit_i    (issue),
		.miss_i   (miss_start),
		.no_acc_o (no_acc_o),
		.no_hit_o (no_hit_o),
		.no_miss_o(no_miss_o)
	);

	fetch_credit #(
		.CREDITS(CREDITS)
	) u_fetch_credit (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.issue_i        (issue),
		.credit_return_i(credit_return_i),
		.pc_i           (pc),
		.pc4_i          (pc4),
		.inst_i         (word),
		.pred_taken_i   (pred_taken_i),
		.has_credit_o   (has_credit),
		.inst_valid_o   (inst_valid_o),
		.pc_d_o         (pc_d_o),
		.inst_d_o       (inst_d_o),
		.pc4_d_o        (pc4_d_o),
		.pred_taken_d_o (pred_taken_d_o)
	);

endmodule

/* rtl/icache_array.sv */
`timescale 1ns/1ps

module icache_array import fetch_pkg::*, cache_pkg::*; #(
	parameter int NUM_LINES = 16
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic [XLEN-1:0]      addr_i,
	input  logic                 fill_en_i,
	input  logic [LINE_BITS-1:0] fill_line_i,
	output logic                 hit_o,
	output logic [XLEN-1:0]      word_o
);

	localparam int IDX_W = $clog2(NUM_LINES);
	localparam int TAG_W = XLEN - IDX_W - OFFSET_BITS;

	logic [NUM_LINES-1:0] valid_q;
	logic [TAG_W-1:0]     tag_q [NUM_LINES];
	// word k of a line sits in slot k at bits [32k+31:32k] of the refill
	logic [WORDS_PER_LINE-1:0][XLEN-1:0] data_q [NUM_LINES];

	logic [IDX_W-1:0]         idx;
	logic [TAG_W-1:0]         tag;
	logic [WORD_SEL_BITS-1:0] wsel;

	assign idx  = addr_i[OFFSET_BITS +: IDX_W];
	assign tag  = addr_i[XLEN-1 -: TAG_W];
	assign wsel = addr_i[BYTE_SEL_BITS +: WORD_SEL_BITS];

	assign hit_o  = valid_q[idx] && (tag_q[idx] == tag);
	assign word_o = data_q[idx][wsel];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else if (fill_en_i) begin
			valid_q[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fill_en_i) begin
			tag_q[idx]  <= tag;
			data_q[idx] <= fill_line_i;
		end
	end

	a_fill_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fill_en_i |-> !$isunknown(addr_i));

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl import fetch_pkg::*, cache_pkg::*; #(
	parameter int NUM_LINES = 16
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic [XLEN-1:0] pc_i,
	input  logic            hit_i,
	input  logic            has_credit_i,
	input  logic            redirect_i,
	input  logic            mem_ready_i,
	output logic            issue_o,
	output logic            miss_start_o,
	output logic            fill_en_o,
	output logic            mem_req_valid_o,
	output logic [XLEN-1:0] mem_req_addr_o,
	output logic            accept_redirect_o,
	output logic            stall_o
);

	localparam int IDX_W = $clog2(NUM_LINES);
	localparam int TAG_W = XLEN - IDX_W - OFFSET_BITS;

	cache_state_e state_q;
	cache_state_e state_d;
	logic [IDX_W-1:0] line_idx;
	logic [TAG_W-1:0] line_tag;
	logic             lookup_go;

	// a lookup only counts with credit and no redirect in flight
	assign lookup_go    = (state_q == LOOKUP) && has_credit_i && !redirect_i;
	assign issue_o      = lookup_go && hit_i;
	assign miss_start_o = lookup_go && !hit_i;

	assign mem_req_valid_o = (state_q == REFILL_REQ) || (state_q == REFILL_WAIT);
	assign fill_en_o       = mem_req_valid_o && mem_ready_i;

	// refill always fetches the whole line
	assign line_idx       = pc_i[OFFSET_BITS +: IDX_W];
	assign line_tag       = pc_i[XLEN-1 -: TAG_W];
	assign mem_req_addr_o = {line_tag, line_idx, {OFFSET_BITS{1'b0}}};

	// pc may only jump outside of refill, or on the fill edge itself
	assign accept_redirect_o = !mem_req_valid_o || mem_ready_i;

	assign stall_o = mem_req_valid_o || ((state_q == LOOKUP) && !has_credit_i);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: state_d = LOOKUP;
			LOOKUP: begin
				if (miss_start_o) begin
					state_d = REFILL_REQ;
				end
			end
			REFILL_REQ: state_d = mem_ready_i ? LOOKUP : REFILL_WAIT;
			REFILL_WAIT: begin
				if (mem_ready_i) begin
					state_d = LOOKUP;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// the pc must not move while memory has not taken the request
	a_req_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mem_req_valid_o && !mem_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o));

	// a line just filled must hit unless the pc moved on the fill edge
	a_fill_then_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fill_en_o |=> !$stable(pc_i) || hit_i);

endmodule

/* rtl/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic            advance_i,
	input  logic            pred_taken_i,
	input  logic [XLEN-1:0] pred_pc_i,
	input  logic            redirect_i,
	input  pc_sel_e         redirect_sel_i,
	input  logic [XLEN-1:0] mispred_pc_i,
	input  logic [XLEN-1:0] alu_pc_i,
	input  logic            accept_redirect_i,
	output logic [XLEN-1:0] pc_o,
	output logic [XLEN-1:0] pc4_o
);

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] pc_next;
	logic [XLEN-1:0] redir_pc;
	logic            pend_q;
	pc_sel_e         pend_sel_q;
	logic [XLEN-1:0] pend_pc_q;
	logic            load;
	pc_sel_e         sel;

	assign pc4_o = pc_q + XLEN'(INST_BYTES);
	assign pc_o  = pc_q;

	// target of the live redirect
	assign redir_pc = (redirect_sel_i == SEL_ALU) ? alu_pc_i : mispred_pc_i;

	// a live redirect wins over a pending one, both win over advance
	always_comb begin
		load = 1'b0;
		sel  = SEL_SEQ;
		if (accept_redirect_i && (redirect_i || pend_q)) begin
			load = 1'b1;
			sel  = redirect_i ? redirect_sel_i : pend_sel_q;
		end else if (advance_i) begin
			load = 1'b1;
			sel  = pred_taken_i ? SEL_PRED : SEL_SEQ;
		end
	end

	always_comb begin
		unique case (sel)
			SEL_SEQ:     pc_next = pc4_o;
			SEL_PRED:    pc_next = pred_pc_i;
			SEL_MISPRED: pc_next = redirect_i ? mispred_pc_i : pend_pc_q;
			SEL_ALU:     pc_next = redirect_i ? alu_pc_i : pend_pc_q;
			default:     pc_next = pc4_o;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pc_q   <= RESET_PC;
			pend_q <= 1'b0;
		end else begin
			if (load) begin
				pc_q <= pc_next;
			end
			// keep a redirect seen during refill until the controller lets it in
			if (accept_redirect_i) begin
				pend_q <= 1'b0;
			end else if (redirect_i) begin
				pend_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!accept_redirect_i && redirect_i) begin
			pend_sel_q <= redirect_sel_i;
			pend_pc_q  <= redir_pc;
		end
	end

endmodule

/* rtl/perf_counter.sv */
`timescale 1ns/1ps

module perf_counter #(
	parameter int CNT_W = 32
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             hit_i,
	input  logic             miss_i,
	output logic [CNT_W-1:0] no_acc_o,
	output logic [CNT_W-1:0] no_hit_o,
	output logic [CNT_W-1:0] no_miss_o
);

	// step by one, stick at all ones
	function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v, input logic en);
		if (en && (v != '1)) begin
			return v + 1'b1;
		end
		return v;
	endfunction

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			no_acc_o  <= '0;
			no_hit_o  <= '0;
			no_miss_o <= '0;
		end else begin
			no_acc_o  <= sat_inc(no_acc_o, hit_i || miss_i);
			no_hit_o  <= sat_inc(no_hit_o, hit_i);
			no_miss_o <= sat_inc(no_miss_o, miss_i);
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f list.f

# the simulator exits nonzero on a fatal check, the search below decides
result=$(./obj_dir/Vtb_fetch || true)
printf '%s\n' "$result"

printf '%s\n' "$result" | grep -qx "Test passed"

/* tb/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*, cache_pkg::*; ();

	localparam int              CREDITS  = 4;
	localparam int              CNT_W    = 32;
	localparam int              NROWS    = 8;
	localparam int              ROW_WAIT = 200;
	localparam logic [XLEN-1:0] INST_KEY = 32'h13570000;
	localparam logic [XLEN-1:0] DECOY_PC = 32'h00000ff0;

	logic                 clk_i = 1'b0;
	logic                 rst_ni;
	logic                 pred_taken_i;
	logic [XLEN-1:0]      pred_pc_i;
	logic                 redirect_i;
	pc_sel_e              redirect_sel_i;
	logic [XLEN-1:0]      mispred_pc_i;
	logic [XLEN-1:0]      alu_pc_i;
	logic                 credit_return_i;
	logic                 inst_valid_o;
	logic [XLEN-1:0]      pc_d_o;
	logic [XLEN-1:0]      inst_d_o;
	logic [XLEN-1:0]      pc4_d_o;
	logic                 pred_taken_d_o;
	logic                 mem_req_valid_o;
	logic [XLEN-1:0]      mem_req_addr_o;
	logic                 mem_ready_i;
	logic [LINE_BITS-1:0] mem_line_i;
	logic                 stall_o;
	logic [CNT_W-1:0]     no_acc_o;
	logic [CNT_W-1:0]     no_hit_o;
	logic [CNT_W-1:0]     no_miss_o;
	int                   req_count;

	// stimulus table with one entry per row
	pc_sel_e         row_sel   [NROWS];
	logic [XLEN-1:0] row_rpc   [NROWS];
	logic            row_pred  [NROWS];
	logic [XLEN-1:0] row_ppc   [NROWS];
	int              row_count [NROWS];
	logic            row_hold  [NROWS];
	logic            row_late  [NROWS];

	// scoreboard
	logic [XLEN-1:0] exp_pc;
	int              held;
	int              issued;
	bit              line_seen [logic [XLEN-1:0]];

	always #50 clk_i = ~clk_i;

	fetch_top dut0 (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.pred_taken_i   (pred_taken_i),
		.pred_pc_i      (pred_pc_i),
		.redirect_i     (redirect_i),
		.redirect_sel_i (redirect_sel_i),
		.mispred_pc_i   (mispred_pc_i),
		.alu_pc_i       (alu_pc_i),
		.credit_return_i(credit_return_i),
		.inst_valid_o   (inst_valid_o),
		.pc_d_o         (pc_d_o),
		.inst_d_o       (inst_d_o),
		.pc4_d_o        (pc4_d_o),
		.pred_taken_d_o (pred_taken_d_o),
		.mem_req_valid_o(mem_req_valid_o),
		.mem_req_addr_o (mem_req_addr_o),
		.mem_ready_i    (mem_ready_i),
		.mem_line_i     (mem_line_i),
		.stall_o        (stall_o),
		.no_acc_o       (no_acc_o),
		.no_hit_o       (no_hit_o),
		.no_miss_o      (no_miss_o)
	);

	tb_mem_model mem0 (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.req_valid_i(mem_req_valid_o),
		.req_addr_i (mem_req_addr_o),
		.ready_o    (mem_ready_i),
		.line_o     (mem_line_i),
		.req_count_o(req_count)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input logic [CNT_W-1:0] got,
		input logic [CNT_W-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	function automatic logic [XLEN-1:0] line_of(input logic [XLEN-1:0] pc);
		return (pc >> OFFSET_BITS) << OFFSET_BITS;
	endfunction

	task automatic add_row(input int r, input pc_sel_e sel, input logic [XLEN-1:0] rpc,
		input logic pred, input logic [XLEN-1:0] ppc, input int cnt, input logic hold,
		input logic late);
		row_sel[r]   = sel;
		row_rpc[r]   = rpc;
		row_pred[r]  = pred;
		row_ppc[r]   = ppc;
		row_count[r] = cnt;
		row_hold[r]  = hold;
		row_late[r]  = late;
	endtask

	// one instruction at the decode boundary
	task automatic take_inst(input logic pred, input logic [XLEN-1:0] target);
		check_word("pc_d_o", pc_d_o, exp_pc);
		check_word("inst_d_o", inst_d_o, exp_pc ^ INST_KEY);
		check_word("pc4_d_o", pc4_d_o, exp_pc + 32'd4);
		check_flag("pred_taken_d_o", pred_taken_d_o, pred);
		line_seen[line_of(exp_pc)] = 1'b1;
		issued++;
		held++;
		exp_pc = pred ? target : exp_pc + 32'd4;
	endtask

	task automatic run_row(input int r);
		int budget;
		int returned;
		int got;
		int cycles;
		bit ret;
		bit pred_pend;
		bit late_pend;
		bit redir_now;
		// credits still in fetch limit how many returns this row needs
		budget    = row_count[r] - (CREDITS - held);
		returned  = 0;
		got       = 0;
		cycles    = 0;
		pred_pend = row_pred[r];
		late_pend = row_late[r] && (row_sel[r] != SEL_SEQ);
		redir_now = !row_late[r] && (row_sel[r] != SEL_SEQ);
		@(posedge clk_i);
		redirect_sel_i <= row_sel[r];
		mispred_pc_i   <= (row_sel[r] == SEL_MISPRED) ? row_rpc[r] : DECOY_PC;
		alu_pc_i       <= (row_sel[r] == SEL_ALU) ? row_rpc[r] : DECOY_PC;
		pred_pc_i      <= row_ppc[r];
		if (redir_now) begin
			exp_pc = row_rpc[r];
		end
		while (got < row_count[r]) begin
			@(posedge clk_i);
			// a predicted row lets one instruction through first
			ret = (held > 0) && (returned < budget) && !(pred_pend && returned > 0);
			credit_return_i <= ret;
			redirect_i      <= redir_now;
			pred_taken_i    <= pred_pend;
			redir_now = 1'b0;
			if (ret) begin
				held--;
				returned++;
			end
			@(negedge clk_i);
			if (inst_valid_o) begin
				take_inst(pred_pend, row_ppc[r]);
				pred_pend = 1'b0;
				got++;
			end
			// redirect lands while the refill is running
			if (late_pend && mem_req_valid_o) begin
				check_word("mem_req_addr_o", mem_req_addr_o, line_of(exp_pc));
				line_seen[line_of(exp_pc)] = 1'b1;
				exp_pc    = row_rpc[r];
				late_pend = 1'b0;
				redir_now = 1'b1;
			end
			cycles++;
			if (cycles > ROW_WAIT) begin
				report_failure($sformatf("timeout in row %0d after %0d of %0d instructions",
					r, got, row_count[r]));
			end
		end
		@(posedge clk_i);
		credit_return_i <= 1'b0;
		redirect_i      <= 1'b0;
		pred_taken_i    <= 1'b0;
		if (late_pend) begin
			report_failure($sformatf("row %0d finished without a refill to redirect into", r));
		end
		if (row_hold[r]) begin
			repeat (12) begin
				@(negedge clk_i);
				check_flag("inst_valid_o", inst_valid_o, 1'b0);
				check_flag("stall_o", stall_o, 1'b1);
			end
		end
		// hits on cached lines must not reach memory
		check_count("mem request count", CNT_W'(req_count), CNT_W'(line_seen.num()));
	endtask

	initial begin
		rst_ni          = 1'b0;
		pred_taken_i    = 1'b0;
		pred_pc_i       = '0;
		redirect_i      = 1'b0;
		redirect_sel_i  = SEL_SEQ;
		mispred_pc_i    = '0;
		alu_pc_i        = '0;
		credit_return_i = 1'b0;
		exp_pc          = '0;
		held            = 0;
		issued          = 0;
		//     row  redirect     target      pred  target  n  hold  late
		add_row(0, SEL_SEQ,     32'h00, 1'b0, 32'h00, 4, 1'b1, 1'b0);
		add_row(1, SEL_SEQ,     32'h00, 1'b0, 32'h00, 6, 1'b0, 1'b0);
		add_row(2, SEL_SEQ,     32'h00, 1'b1, 32'h40, 3, 1'b0, 1'b0);
		add_row(3, SEL_MISPRED, 32'h80, 1'b0, 32'h00, 4, 1'b0, 1'b0);
		add_row(4, SEL_ALU,     32'h60, 1'b0, 32'h00, 3, 1'b0, 1'b1);
		add_row(5, SEL_MISPRED, 32'hc0, 1'b0, 32'h00, 4, 1'b1, 1'b1);
		add_row(6, SEL_ALU,     32'h10, 1'b0, 32'h00, 8, 1'b0, 1'b0);
		add_row(7, SEL_SEQ,     32'h00, 1'b0, 32'h00, 2, 1'b0, 1'b0);
		repeat (7) @(posedge clk_i);
		@(negedge clk_i);
		check_flag("inst_valid_o", inst_valid_o, 1'b0);
		check_flag("mem_req_valid_o", mem_req_valid_o, 1'b0);
		check_flag("stall_o", stall_o, 1'b0);
		check_count("no_acc_o", no_acc_o, '0);
		check_count("no_hit_o", no_hit_o, '0);
		check_count("no_miss_o", no_miss_o, '0);
		@(posedge clk_i);
		rst_ni <= 1'b1;
		for (int r = 0; r < NROWS; r++) begin
			run_row(r);
		end
		@(negedge clk_i);
		check_count("no_miss_o", no_miss_o, CNT_W'(line_seen.num()));
		check_count("no_hit_o", no_hit_o, CNT_W'(issued));
		check_count("no_acc_o", no_acc_o, CNT_W'(line_seen.num() + issued));
		$display("Test passed");
		$finish;
	end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model import fetch_pkg::*, cache_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 req_valid_i,
	input  logic [XLEN-1:0]      req_addr_i,
	output logic                 ready_o,
	output logic [LINE_BITS-1:0] line_o,
	output int                   req_count_o
);

	localparam logic [XLEN-1:0] INST_KEY = 32'h13570000;

	logic [31:0] lfsr;
	logic [2:0]  draw;
	logic        busy;
	int          wait_left;

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h00000000);
	endfunction

	// word k of the line at a holds (a + 4k) ^ key
	function automatic logic [LINE_BITS-1:0] line_at(input logic [XLEN-1:0] a);
		logic [LINE_BITS-1:0] l;
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			l[XLEN*k +: XLEN] = (a + XLEN'(4 * k)) ^ INST_KEY;
		end
		return l;
	endfunction

	always @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			lfsr = 32'he8a6bf24;
			busy        <= 1'b0;
			wait_left   <= 0;
			ready_o     <= 1'b0;
			line_o      <= '0;
			req_count_o <= 0;
		end else begin
			ready_o <= 1'b0;
			if (busy) begin
				if (wait_left == 0) begin
					ready_o <= 1'b1;
					line_o  <= line_at(req_addr_i);
					busy    <= 1'b0;
				end else begin
					wait_left <= wait_left - 1;
				end
			end else if (req_valid_i && !ready_o) begin
				// one lfsr step per bit for a latency of 1 to 8 cycles
				for (int b = 0; b < 3; b++) begin
					draw = {draw[1:0], lfsr[0]};
					lfsr = lfsr_next(lfsr);
				end
				req_count_o <= req_count_o + 1;
				if (draw == 3'd0) begin
					ready_o <= 1'b1;
					line_o  <= line_at(req_addr_i);
				end else begin
					busy      <= 1'b1;
					wait_left <= int'(draw) - 1;
				end
			end
		end
	end

endmodule
